//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= periph_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "TEST FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "TEST PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- files.f
hw/periph_pkg.sv
hw/apb_far_bridge.sv
hw/periph_timer.sv
hw/periph_sysreg.sv
hw/irq_return_combine.sv
hw/periph_top.sv
tb/periph_tb.sv

//--- hw/apb_far_bridge.sv
`timescale 1ns/1ps

module apb_far_bridge import periph_pkg::*; (
	input  logic                 i_clock,
	input  logic                 i_rst_n,

	// APB slave side
	input  logic                 i_psel,
	input  logic                 i_penable,
	input  logic                 i_pwrite,
	input  logic [ADDR_W-1:0]    i_paddr,
	input  logic [DATA_W-1:0]    i_pwdata,
	output logic [DATA_W-1:0]    o_prdata,
	output logic                 o_pready,
	output logic                 o_pslverr,

	// Far bus side
	output logic                 o_timer_req,
	output logic                 o_sysreg_req,
	output logic                 o_plic_req,
	output logic                 o_far_write,
	output logic [REG_OFS_W-1:0] o_far_ofs,
	output logic [DATA_W-1:0]    o_far_wdata,
	output region_e              o_far_region,
	input  logic [DATA_W-1:0]    i_ret_rdata,
	input  logic                 i_ret_err
);

	apb_state_e state;
	region_e    dec_region;
	logic       setup;

	// Only a setup phase seen in IDLE starts a transfer
	assign setup = (state == IDLE) && i_psel && !i_penable;

	// Region decode on the top nibble of the far address
	always_comb begin
		case (i_paddr[REGION_LSB +: 4])
			REGION_TIMER, REGION_PLIC, REGION_SYSREG:
				dec_region = region_e'(i_paddr[REGION_LSB +: 4]);
			default:
				dec_region = REGION_NONE;
		endcase
	end

	// ========================================
	// State machine
	// ========================================

	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state <= IDLE;
		end else begin
			case (state)
				IDLE:    if (setup) state <= ACCESS;
				ACCESS:  state <= RESPOND;
				RESPOND: state <= IDLE;
				default: state <= IDLE;
			endcase
		end
	end

	// Strobes are high for the first access cycle only
	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_timer_req  <= 1'b0;
			o_sysreg_req <= 1'b0;
			o_plic_req   <= 1'b0;
			o_far_write  <= 1'b0;
			o_far_region <= REGION_NONE;
		end else begin
			o_timer_req  <= setup && (dec_region == REGION_TIMER);
			o_sysreg_req <= setup && (dec_region == REGION_SYSREG);
			o_plic_req   <= setup && (dec_region == REGION_PLIC);
			if (setup) begin
				o_far_write  <= i_pwrite;
				o_far_region <= dec_region;
			end
		end
	end

	// Offset and write word captured with the setup phase
	always_ff @(posedge i_clock) begin
		if (setup) begin
			o_far_ofs   <= i_paddr[OFS_LSB +: REG_OFS_W];
			o_far_wdata <= i_pwdata;
		end
	end

	// ========================================
	// Response after one wait state
	// ========================================

	assign o_pready  = (state == RESPOND);
	assign o_pslverr = (state == RESPOND) && i_ret_err;
	assign o_prdata  = (state == RESPOND) ? i_ret_rdata : '0;

endmodule

//--- hw/irq_return_combine.sv
`timescale 1ns/1ps

module irq_return_combine import periph_pkg::*; (
	input  logic                 i_clock,
	input  logic                 i_rst_n,
	input  logic                 i_plic_req,
	input  logic                 i_write,
	input  logic [REG_OFS_W-1:0] i_ofs,
	input  logic [DATA_W-1:0]    i_wdata,
	input  region_e              i_region,
	input  logic [DATA_W-1:0]    i_timer_rdata,
	input  logic [DATA_W-1:0]    i_sysreg_rdata,
	input  logic                 i_timer_irq,
	input  logic                 i_swi_irq,
	output logic [DATA_W-1:0]    o_ret_rdata,
	output logic                 o_ret_err,
	output logic                 o_irq
);

	localparam int CLAIM_W = $clog2(IRQ_SRC_N + 1);

	logic [IRQ_SRC_N-1:0] src;
	logic [IRQ_SRC_N-1:0] src_q;
	logic [IRQ_SRC_N-1:0] rise;
	logic [IRQ_SRC_N-1:0] pending;
	logic [IRQ_SRC_N-1:0] enable;
	logic [IRQ_SRC_N-1:0] active;
	logic [IRQ_SRC_N-1:0] claim_clr;
	logic [CLAIM_W-1:0]   claim_id;
	logic [DATA_W-1:0]    plic_word;
	logic [DATA_W-1:0]    plic_rdata;
	logic                 wr;

	// Source 1 is the timer, source 2 the software interrupt
	assign src    = {i_swi_irq, i_timer_irq};
	assign rise   = src & ~src_q;
	assign active = pending & enable;
	assign wr     = i_plic_req && i_write;

	// ========================================
	// Claim logic
	// ========================================

	// Lowest numbered active source wins
	always_comb begin
		claim_id = '0;
		for (int i = IRQ_SRC_N - 1; i >= 0; i--) begin
			if (active[i])
				claim_id = CLAIM_W'(i + 1);
		end
	end

	// Writing n to CLAIM retires source n
	always_comb begin
		for (int i = 0; i < IRQ_SRC_N; i++)
			claim_clr[i] = wr && (i_ofs == PLIC_CLAIM) && (i_wdata == DATA_W'(i + 1));
	end

	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			src_q   <= '0;
			pending <= '0;
			enable  <= '0;
			o_irq   <= 1'b0;
		end else begin
			src_q   <= src;
			pending <= (pending & ~claim_clr) | rise;
			if (wr && (i_ofs == PLIC_ENABLE))
				enable <= i_wdata[IRQ_SRC_N-1:0];
			o_irq <= |active;
		end
	end

	// ========================================
	// Register reads and return path
	// ========================================

	always_comb begin
		case (plic_reg_e'(i_ofs))
			PLIC_PENDING: plic_word = {{(DATA_W-IRQ_SRC_N){1'b0}}, pending};
			PLIC_ENABLE:  plic_word = {{(DATA_W-IRQ_SRC_N){1'b0}}, enable};
			PLIC_CLAIM:   plic_word = {{(DATA_W-CLAIM_W){1'b0}}, claim_id};
			default:      plic_word = '0;
		endcase
	end

	always_ff @(posedge i_clock) begin
		if (i_plic_req)
			plic_rdata <= plic_word;
	end

	always_comb begin
		o_ret_err = 1'b0;
		case (i_region)
			REGION_TIMER:  o_ret_rdata = i_timer_rdata;
			REGION_SYSREG: o_ret_rdata = i_sysreg_rdata;
			REGION_PLIC:   o_ret_rdata = plic_rdata;
			default: begin
				o_ret_rdata = '0;
				o_ret_err   = 1'b1;
			end
		endcase
	end

endmodule

//--- hw/periph_pkg.sv
package periph_pkg;

	// ========================================
	// Widths
	// ========================================

	localparam int ADDR_W     = 28;
	localparam int DATA_W     = 32;
	localparam int REG_OFS_W  = 3;
	localparam int LED_W      = 8;
	localparam int IRQ_SRC_N  = 2;

	// Address fields of the far bus
	localparam int REGION_LSB = 24;
	localparam int OFS_LSB    = 2;

	// ========================================
	// Encodings
	// ========================================

	// Far regions on address bits 27:24
	typedef enum logic [3:0] {
		REGION_NONE   = 4'h0,
		REGION_TIMER  = 4'h5,
		REGION_PLIC   = 4'h8,
		REGION_SYSREG = 4'h9
	} region_e;

	typedef enum logic [1:0] {
		IDLE,
		ACCESS,
		RESPOND
	} apb_state_e;

	// Word offsets inside each region
	typedef enum logic [REG_OFS_W-1:0] {
		TMR_COUNT   = 3'd0,
		TMR_COMPARE = 3'd1,
		TMR_CTRL    = 3'd2,
		TMR_STATUS  = 3'd3
	} timer_reg_e;

	typedef enum logic [REG_OFS_W-1:0] {
		SYS_DEVICE_ID = 3'd0,
		SYS_LEDS      = 3'd1,
		SYS_SCRATCH   = 3'd2,
		SYS_SWI       = 3'd3
	} sysreg_reg_e;

	typedef enum logic [REG_OFS_W-1:0] {
		PLIC_PENDING = 3'd0,
		PLIC_ENABLE  = 3'd1,
		PLIC_CLAIM   = 3'd2
	} plic_reg_e;

endpackage

//--- hw/periph_sysreg.sv
`timescale 1ns/1ps

module periph_sysreg import periph_pkg::*; #(
	parameter int DEVICE_ID = 6
) (
	input  logic                 i_clock,
	input  logic                 i_rst_n,
	input  logic                 i_req,
	input  logic                 i_write,
	input  logic [REG_OFS_W-1:0] i_ofs,
	input  logic [DATA_W-1:0]    i_wdata,
	output logic [DATA_W-1:0]    o_rdata,
	output logic [LED_W-1:0]     o_leds,
	output logic                 o_swi_irq
);

	logic [DATA_W-1:0] scratch;
	logic [DATA_W-1:0] rd_word;
	logic              wr;

	assign wr = i_req && i_write;

	// ========================================
	// Control registers
	// ========================================

	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_leds    <= '0;
			o_swi_irq <= 1'b0;
		end else if (wr) begin
			case (sysreg_reg_e'(i_ofs))
				SYS_LEDS: o_leds    <= i_wdata[LED_W-1:0];
				SYS_SWI:  o_swi_irq <= i_wdata[0];
				default:  ;
			endcase
		end
	end

	// Scratch word for software
	always_ff @(posedge i_clock) begin
		if (wr && (i_ofs == SYS_SCRATCH))
			scratch <= i_wdata;
	end

	// ========================================
	// Read back
	// ========================================

	always_comb begin
		case (sysreg_reg_e'(i_ofs))
			SYS_DEVICE_ID: rd_word = DATA_W'(DEVICE_ID);
			SYS_LEDS:      rd_word = {{(DATA_W-LED_W){1'b0}}, o_leds};
			SYS_SCRATCH:   rd_word = scratch;
			SYS_SWI:       rd_word = {{(DATA_W-1){1'b0}}, o_swi_irq};
			default:       rd_word = '0;
		endcase
	end

	always_ff @(posedge i_clock) begin
		if (i_req)
			o_rdata <= rd_word;
	end

endmodule

//--- hw/periph_timer.sv
`timescale 1ns/1ps

module periph_timer import periph_pkg::*; #(
	parameter int TICK_DIV = 4
) (
	input  logic                 i_clock,
	input  logic                 i_rst_n,
	input  logic                 i_req,
	input  logic                 i_write,
	input  logic [REG_OFS_W-1:0] i_ofs,
	input  logic [DATA_W-1:0]    i_wdata,
	output logic [DATA_W-1:0]    o_rdata,
	output logic                 o_timer_irq
);

	localparam int PRESC_W = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;

	logic [PRESC_W-1:0] presc;
	logic [DATA_W-1:0]  count;
	logic [DATA_W-1:0]  count_next;
	logic [DATA_W-1:0]  compare;
	logic [DATA_W-1:0]  rd_word;
	logic               enable;
	logic               flag;
	logic               tick;
	logic               wr;

	assign wr         = i_req && i_write;
	assign count_next = count + DATA_W'(1);

	// One tick every TICK_DIV clocks while running
	assign tick = enable && (presc == PRESC_W'(TICK_DIV - 1));

	// ========================================
	// Prescaler and counter
	// ========================================

	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			presc <= '0;
			count <= '0;
		end else begin
			if (!enable || tick)
				presc <= '0;
			else
				presc <= presc + PRESC_W'(1);
			if (tick)
				count <= count_next;
		end
	end

	// ========================================
	// Registers
	// ========================================

	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			compare <= '0;
			enable  <= 1'b0;
			flag    <= 1'b0;
		end else begin
			if (wr && (i_ofs == TMR_COMPARE))
				compare <= i_wdata;
			if (wr && (i_ofs == TMR_CTRL))
				enable <= i_wdata[0];
			// Match wins over a clear in the same cycle
			if (tick && (count_next == compare))
				flag <= 1'b1;
			else if (wr && (i_ofs == TMR_STATUS) && i_wdata[0])
				flag <= 1'b0;
		end
	end

	always_comb begin
		case (timer_reg_e'(i_ofs))
			TMR_COUNT:   rd_word = count;
			TMR_COMPARE: rd_word = compare;
			TMR_CTRL:    rd_word = {{(DATA_W-1){1'b0}}, enable};
			TMR_STATUS:  rd_word = {{(DATA_W-1){1'b0}}, flag};
			default:     rd_word = '0;
		endcase
	end

	// Read word of the last request
	always_ff @(posedge i_clock) begin
		if (i_req)
			o_rdata <= rd_word;
	end

	assign o_timer_irq = flag;

endmodule

//--- hw/periph_top.sv
`timescale 1ns/1ps

module periph_top import periph_pkg::*; #(
	parameter int TICK_DIV  = 4,
	parameter int DEVICE_ID = 6
) (
	input  logic              i_clock,
	input  logic              i_rst_n,

	// APB port
	input  logic              i_psel,
	input  logic              i_penable,
	input  logic              i_pwrite,
	input  logic [ADDR_W-1:0] i_paddr,
	input  logic [DATA_W-1:0] i_pwdata,
	output logic [DATA_W-1:0] o_prdata,
	output logic              o_pready,
	output logic              o_pslverr,

	output logic [LED_W-1:0]  o_leds,
	output logic              o_irq
);

	// Far bus
	logic                 timer_req;
	logic                 sysreg_req;
	logic                 plic_req;
	logic                 far_write;
	logic [REG_OFS_W-1:0] far_ofs;
	logic [DATA_W-1:0]    far_wdata;
	region_e              far_region;

	// Results
	logic [DATA_W-1:0]    timer_rdata;
	logic [DATA_W-1:0]    sysreg_rdata;
	logic [DATA_W-1:0]    ret_rdata;
	logic                 ret_err;
	logic                 timer_irq;
	logic                 swi_irq;

	// ========================================
	// Bridge
	// ========================================

	apb_far_bridge bridge_i (
		.i_clock      (i_clock),
		.i_rst_n      (i_rst_n),
		.i_psel       (i_psel),
		.i_penable    (i_penable),
		.i_pwrite     (i_pwrite),
		.i_paddr      (i_paddr),
		.i_pwdata     (i_pwdata),
		.o_prdata     (o_prdata),
		.o_pready     (o_pready),
		.o_pslverr    (o_pslverr),
		.o_timer_req  (timer_req),
		.o_sysreg_req (sysreg_req),
		.o_plic_req   (plic_req),
		.o_far_write  (far_write),
		.o_far_ofs    (far_ofs),
		.o_far_wdata  (far_wdata),
		.o_far_region (far_region),
		.i_ret_rdata  (ret_rdata),
		.i_ret_err    (ret_err)
	);

	// ========================================
	// Peripherals
	// ========================================

	periph_timer #(
		.TICK_DIV (TICK_DIV)
	) timer_i (
		.i_clock     (i_clock),
		.i_rst_n     (i_rst_n),
		.i_req       (timer_req),
		.i_write     (far_write),
		.i_ofs       (far_ofs),
		.i_wdata     (far_wdata),
		.o_rdata     (timer_rdata),
		.o_timer_irq (timer_irq)
	);

	periph_sysreg #(
		.DEVICE_ID (DEVICE_ID)
	) sysreg_i (
		.i_clock   (i_clock),
		.i_rst_n   (i_rst_n),
		.i_req     (sysreg_req),
		.i_write   (far_write),
		.i_ofs     (far_ofs),
		.i_wdata   (far_wdata),
		.o_rdata   (sysreg_rdata),
		.o_leds    (o_leds),
		.o_swi_irq (swi_irq)
	);

	// Interrupts and read return
	irq_return_combine combine_i (
		.i_clock        (i_clock),
		.i_rst_n        (i_rst_n),
		.i_plic_req     (plic_req),
		.i_write        (far_write),
		.i_ofs          (far_ofs),
		.i_wdata        (far_wdata),
		.i_region       (far_region),
		.i_timer_rdata  (timer_rdata),
		.i_sysreg_rdata (sysreg_rdata),
		.i_timer_irq    (timer_irq),
		.i_swi_irq      (swi_irq),
		.o_ret_rdata    (ret_rdata),
		.o_ret_err      (ret_err),
		.o_irq          (o_irq)
	);

endmodule

//--- tb/periph_tb.sv
`timescale 1ns/1ps

module periph_tb import periph_pkg::*; ();

	localparam int TICK_DIV     = 4;
	localparam int DEVICE_ID    = 6;
	localparam int RST_CYCLES   = 5;
	localparam int ACCESS_LIMIT = 8;

	localparam logic [DATA_W-1:0] ONES = '1;

	// Expected o_irq codes where IRQ_ANY skips the check
	localparam logic [1:0] IRQ_LO  = 2'd0;
	localparam logic [1:0] IRQ_HI  = 2'd1;
	localparam logic [1:0] IRQ_ANY = 2'd2;

	typedef enum logic [2:0] {
		OP_WRITE,
		OP_READ,
		OP_WAIT,
		OP_READ_CAP,
		OP_READ_GT,
		OP_WRITE_CMP
	} op_e;

	typedef struct packed {
		op_e               op;
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] wdata;
		logic [DATA_W-1:0] exp_rdata;
		logic [DATA_W-1:0] mask;
		logic              exp_err;
		logic [1:0]        exp_irq;
		logic [LED_W-1:0]  exp_leds;
	} entry_t;

	logic              i_clock;
	logic              i_rst_n;
	logic              i_psel;
	logic              i_penable;
	logic              i_pwrite;
	logic [ADDR_W-1:0] i_paddr;
	logic [DATA_W-1:0] i_pwdata;
	logic [DATA_W-1:0] o_prdata;
	logic              o_pready;
	logic              o_pslverr;
	logic [LED_W-1:0]  o_leds;
	logic              o_irq;

	entry_t            tests[$];
	int                pass_cnt = 0;
	int                fail_cnt = 0;
	int                wait_total = 0;
	int                cycle_limit = 0;
	int                cycles = 0;
	logic [DATA_W-1:0] last_count;
	logic [DATA_W-1:0] scratch_val;
	logic [LED_W-1:0]  leds_now;

	periph_top #(
		.TICK_DIV  (TICK_DIV),
		.DEVICE_ID (DEVICE_ID)
	) periph_top_i (
		.i_clock   (i_clock),
		.i_rst_n   (i_rst_n),
		.i_psel    (i_psel),
		.i_penable (i_penable),
		.i_pwrite  (i_pwrite),
		.i_paddr   (i_paddr),
		.i_pwdata  (i_pwdata),
		.o_prdata  (o_prdata),
		.o_pready  (o_pready),
		.o_pslverr (o_pslverr),
		.o_leds    (o_leds),
		.o_irq     (o_irq)
	);

	always #10 i_clock = ~i_clock;

	// Run limit
	always @(posedge i_clock) begin
		cycles <= cycles + 1;
		if (cycle_limit > 0 && cycles >= cycle_limit) begin
			$display("timeout: the run did not finish within %0d clock cycles", cycles);
			$display("TEST FAIL");
			$finish;
		end
	end

	// ========================================
	// Stimulus table
	// ========================================

	// Region in bits 27:24, word offset in bits 4:2
	function automatic logic [ADDR_W-1:0] reg_addr(input logic [3:0] region,
			input logic [REG_OFS_W-1:0] ofs);
		reg_addr = {region, {(ADDR_W-9){1'b0}}, ofs, 2'b00};
	endfunction

	task automatic push_entry(input op_e op, input logic [ADDR_W-1:0] addr,
			input logic [DATA_W-1:0] wdata, input logic [DATA_W-1:0] exp_rdata,
			input logic [DATA_W-1:0] mask, input logic exp_err, input logic [1:0] exp_irq);
		entry_t e;
		e.op        = op;
		e.addr      = addr;
		e.wdata     = wdata;
		e.exp_rdata = exp_rdata;
		e.mask      = mask;
		e.exp_err   = exp_err;
		e.exp_irq   = exp_irq;
		e.exp_leds  = leds_now;
		tests.push_back(e);
	endtask

	// Error writes still return zero data
	task automatic add_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] wdata,
			input logic exp_err, input logic [1:0] exp_irq);
		push_entry(OP_WRITE, addr, wdata, '0, exp_err ? ONES : '0, exp_err, exp_irq);
	endtask

	task automatic add_read(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] exp_rdata,
			input logic exp_err, input logic [1:0] exp_irq);
		push_entry(OP_READ, addr, '0, exp_rdata, ONES, exp_err, exp_irq);
	endtask

	task automatic add_wait(input int n);
		push_entry(OP_WAIT, '0, DATA_W'(n), '0, '0, 1'b0, IRQ_ANY);
		wait_total += n;
	endtask

	task automatic build_table();
		leds_now = '0;
		// System registers
		add_read(reg_addr(REGION_SYSREG, SYS_DEVICE_ID), DATA_W'(DEVICE_ID), 1'b0, IRQ_LO);
		leds_now = 8'ha5;
		add_write(reg_addr(REGION_SYSREG, SYS_LEDS), 32'h0000_00a5, 1'b0, IRQ_LO);
		add_read(reg_addr(REGION_SYSREG, SYS_LEDS), 32'h0000_00a5, 1'b0, IRQ_LO);
		add_write(reg_addr(REGION_SYSREG, SYS_SCRATCH), scratch_val, 1'b0, IRQ_LO);
		add_read(reg_addr(REGION_SYSREG, SYS_SCRATCH), scratch_val, 1'b0, IRQ_LO);
		add_write(reg_addr(REGION_SYSREG, SYS_DEVICE_ID), 32'h0000_1234, 1'b0, IRQ_LO);
		add_read(reg_addr(REGION_SYSREG, SYS_DEVICE_ID), DATA_W'(DEVICE_ID), 1'b0, IRQ_LO);

		// Timer with source 1 enabled
		add_write(reg_addr(REGION_PLIC, PLIC_ENABLE), 32'd1, 1'b0, IRQ_LO);
		add_write(reg_addr(REGION_TIMER, TMR_CTRL), 32'd1, 1'b0, IRQ_LO);
		push_entry(OP_READ_CAP, reg_addr(REGION_TIMER, TMR_COUNT), '0, '0, '0, 1'b0, IRQ_LO);
		add_wait(20);
		push_entry(OP_READ_GT, reg_addr(REGION_TIMER, TMR_COUNT), '0, '0, '0, 1'b0, IRQ_LO);
		// Compare three ticks past the last count read
		push_entry(OP_WRITE_CMP, reg_addr(REGION_TIMER, TMR_COMPARE), 32'd3, '0, '0, 1'b0,
			IRQ_LO);
		add_wait(40);
		add_read(reg_addr(REGION_TIMER, TMR_STATUS), 32'd1, 1'b0, IRQ_HI);
		add_read(reg_addr(REGION_PLIC, PLIC_CLAIM), 32'd1, 1'b0, IRQ_HI);
		add_write(reg_addr(REGION_PLIC, PLIC_CLAIM), 32'd1, 1'b0, IRQ_ANY);
		add_write(reg_addr(REGION_TIMER, TMR_STATUS), 32'd1, 1'b0, IRQ_ANY);
		add_read(reg_addr(REGION_PLIC, PLIC_PENDING), 32'd0, 1'b0, IRQ_LO);
		add_read(reg_addr(REGION_TIMER, TMR_STATUS), 32'd0, 1'b0, IRQ_LO);

		// Software interrupt starts masked
		add_write(reg_addr(REGION_PLIC, PLIC_ENABLE), 32'd0, 1'b0, IRQ_LO);
		add_write(reg_addr(REGION_SYSREG, SYS_SWI), 32'd1, 1'b0, IRQ_LO);
		add_read(reg_addr(REGION_PLIC, PLIC_PENDING), 32'd2, 1'b0, IRQ_LO);
		add_write(reg_addr(REGION_PLIC, PLIC_ENABLE), 32'd2, 1'b0, IRQ_ANY);
		add_read(reg_addr(REGION_PLIC, PLIC_CLAIM), 32'd2, 1'b0, IRQ_HI);
		add_write(reg_addr(REGION_PLIC, PLIC_CLAIM), 32'd2, 1'b0, IRQ_ANY);
		add_write(reg_addr(REGION_SYSREG, SYS_SWI), 32'd0, 1'b0, IRQ_ANY);
		add_read(reg_addr(REGION_PLIC, PLIC_PENDING), 32'd0, 1'b0, IRQ_LO);

		// Unmapped regions, then the registers they must not touch
		add_read(reg_addr(4'h0, 3'd0), 32'd0, 1'b1, IRQ_LO);
		add_write(reg_addr(4'h3, 3'd1), 32'h0000_00ff, 1'b1, IRQ_LO);
		add_read(reg_addr(4'hf, 3'd2), 32'd0, 1'b1, IRQ_LO);
		add_write(reg_addr(4'h0, 3'd2), 32'h0000_005a, 1'b1, IRQ_LO);
		add_read(reg_addr(REGION_SYSREG, SYS_LEDS), 32'h0000_00a5, 1'b0, IRQ_LO);
		add_read(reg_addr(REGION_SYSREG, SYS_SCRATCH), scratch_val, 1'b0, IRQ_LO);
	endtask

	// ========================================
	// APB driver
	// ========================================

	task automatic idle_cycles(input int n);
		@(posedge i_clock);
		i_psel    <= 1'b0;
		i_penable <= 1'b0;
		repeat (n) @(posedge i_clock);
	endtask

	// Setup, then access until pready, sampled on the falling edge
	task automatic apb_transfer(input logic write, input logic [ADDR_W-1:0] addr,
			input logic [DATA_W-1:0] wdata, output logic [DATA_W-1:0] rdata,
			output logic err, output int waits);
		@(posedge i_clock);
		i_psel    <= 1'b1;
		i_penable <= 1'b0;
		i_pwrite  <= write;
		i_paddr   <= addr;
		i_pwdata  <= wdata;
		@(posedge i_clock);
		i_penable <= 1'b1;
		waits = 0;
		do begin
			@(negedge i_clock);
			waits++;
		end while (!o_pready && waits < ACCESS_LIMIT);
		rdata = o_prdata;
		err   = o_pslverr;
	endtask

	task automatic run_entry(input int idx);
		entry_t            e;
		logic [DATA_W-1:0] wdata;
		logic [DATA_W-1:0] rdata;
		logic              err;
		logic              ok;
		int                waits;
		e  = tests[idx];
		ok = 1'b1;
		if (e.op == OP_WAIT) begin
			idle_cycles(int'(e.wdata));
		end else begin
			wdata = (e.op == OP_WRITE_CMP) ? last_count + e.wdata : e.wdata;
			apb_transfer(e.op == OP_WRITE || e.op == OP_WRITE_CMP, e.addr, wdata,
				rdata, err, waits);
			assert (o_pready && waits == 2) else begin
				$display("pready did not come on the second access cycle (waited %0d)", waits);
				ok = 1'b0;
			end
			assert (err == e.exp_err) else begin
				$display("error: o_pslverr got %h expected %h", err, e.exp_err);
				ok = 1'b0;
			end
			assert ((rdata & e.mask) == (e.exp_rdata & e.mask)) else begin
				$display("error: o_prdata got %h expected %h", rdata, e.exp_rdata);
				ok = 1'b0;
			end
			if (e.op == OP_READ_GT) begin
				assert (rdata > last_count) else begin
					$display("error: o_prdata got %h expected above %h", rdata, last_count);
					ok = 1'b0;
				end
			end
			if (e.exp_irq != IRQ_ANY) begin
				assert (o_irq == e.exp_irq[0]) else begin
					$display("error: o_irq got %h expected %h", o_irq, e.exp_irq[0]);
					ok = 1'b0;
				end
			end
			assert (o_leds == e.exp_leds) else begin
				$display("error: o_leds got %h expected %h", o_leds, e.exp_leds);
				ok = 1'b0;
			end
			if (e.op == OP_READ_CAP || e.op == OP_READ_GT)
				last_count = rdata;
		end
		if (ok) begin
			pass_cnt++;
			$display("test %0d op %0d addr %h: ok", idx, e.op, e.addr);
		end else begin
			fail_cnt++;
			$display("test %0d op %0d addr %h: failed", idx, e.op, e.addr);
		end
	endtask

	// ========================================
	// Main sequence
	// ========================================

	initial begin
		i_clock    = 1'b0;
		i_rst_n    = 1'b0;
		i_psel     = 1'b0;
		i_penable  = 1'b0;
		i_pwrite   = 1'b0;
		i_paddr    = '0;
		i_pwdata   = '0;
		last_count = '0;
		void'($urandom(96157));
		scratch_val = $urandom();
		build_table();
		cycle_limit = 20 * tests.size() + wait_total;

		repeat (RST_CYCLES) @(posedge i_clock);
		i_rst_n <= 1'b1;

		for (int i = 0; i < tests.size(); i++)
			run_entry(i);
		idle_cycles(2);

		$display("tests passed %0d, failed %0d", pass_cnt, fail_cnt);
		if (fail_cnt == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule
